// File: design/booth_mult.sv
// Radix-4 Booth signed multiplier with one register stage.
// The product comes out one cycle after in_valid, along with out_valid.
`timescale 1ns/1ps

module booth_mult (
    input  logic                s_clk,
    input  logic                s_rst,
    input  logic                in_valid,
    input  systolic_pkg::data_t multiplicand,
    input  systolic_pkg::data_t multiplier,
    output logic                out_valid,
    output systolic_pkg::psum_t product
);
    import systolic_pkg::*;

    // one Booth digit per pair of multiplier bits
    localparam int NUM_DIGITS = DATA_WIDTH / 2;

    logic [DATA_WIDTH:0] recode_bits;
    psum_t               mcand;
    psum_t               partial;
    psum_t               sum;

    // implicit zero below the lsb for the first digit
    assign recode_bits = {multiplier, 1'b0};

    // sign-extended so that 2x(-128) still fits
    assign mcand = psum_t'(multiplicand);

    always_comb begin
        sum     = '0;
        partial = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            // digit from bits 2i+1, 2i and 2i-1 of the multiplier
            case (recode_bits[2*i +: 3])
                3'b001, 3'b010: partial = mcand;
                3'b011:         partial = mcand <<< 1;
                3'b100:         partial = -(mcand <<< 1);
                3'b101, 3'b110: partial = -mcand;
                default:        partial = '0;
            endcase
            sum = sum + (partial <<< (2 * i));
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            out_valid <= 1'b0;
            product   <= '0;
        end else begin
            out_valid <= in_valid;
            product   <= sum;
        end
    end

endmodule

// File: design/psum_deskew_collector.sv
// Realigns the staggered bottom-row sums of the grid into one result row.
// The row leaves through an output register as a single-cycle strobe.
`timescale 1ns/1ps

module psum_deskew_collector (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  systolic_pkg::psum_row_t bottom,
    output systolic_pkg::psum_row_t c_out
);
    import systolic_pkg::*;

    psum_t aligned [ARRAY_DIM];

    // column j finishes ARRAY_DIM-1-j cycles before the last one
    for (genvar j = 0; j < ARRAY_DIM; j++) begin : g_col
        localparam int DEPTH = ARRAY_DIM - 1 - j;

        if (DEPTH == 0) begin : g_direct
            assign aligned[j] = bottom.psum[j];
        end else begin : g_delay
            psum_t line [DEPTH];

            always_ff @(posedge s_clk) begin
                line[0] <= bottom.psum[j];
                for (int s = 1; s < DEPTH; s++) begin
                    line[s] <= line[s-1];
                end
            end

            assign aligned[j] = line[DEPTH-1];
        end
    end

    // bottom.valid already belongs to the last column, no delay needed
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            c_out <= '0;
        end else begin
            c_out.valid <= bottom.valid;
            for (int j = 0; j < ARRAY_DIM; j++) begin
                c_out.psum[j] <= aligned[j];
            end
        end
    end

endmodule

// File: design/row_skew_feeder.sv
// Turns one input row into the skewed lane bus for the left edge of the grid.
// Lane k leaves k+1 cycles after the row strobe.
`timescale 1ns/1ps

module row_skew_feeder (
    input  logic                 s_clk,
    input  logic                 s_rst,
    input  systolic_pkg::a_row_t a_in,
    output systolic_pkg::a_row_t a_lanes
);
    import systolic_pkg::*;

    logic  lane0_valid;
    data_t lane_data [ARRAY_DIM];

    // valid travels with lane 0, the grid rebuilds it for later lanes
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            lane0_valid <= 1'b0;
        end else begin
            lane0_valid <= a_in.valid;
        end
    end

    // lane k is a shift register k+1 deep
    for (genvar k = 0; k < ARRAY_DIM; k++) begin : g_lane
        data_t stage [k+1];

        always_ff @(posedge s_clk) begin
            stage[0] <= a_in.data[k];
            for (int s = 1; s <= k; s++) begin
                stage[s] <= stage[s-1];
            end
        end

        assign lane_data[k] = stage[k];
    end

    always_comb begin
        a_lanes.valid = lane0_valid;
        for (int k = 0; k < ARRAY_DIM; k++) begin
            a_lanes.data[k] = lane_data[k];
        end
    end

endmodule

// File: design/systolic_grid.sv
// ARRAY_DIM x ARRAY_DIM mesh of PEs holding the weight matrix.
// Skewed lanes enter on the left, and column sums leave at the bottom, staggered by column.
`timescale 1ns/1ps

module systolic_grid (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  systolic_pkg::w_load_t   w_load,
    input  systolic_pkg::a_row_t    a_lanes,
    output systolic_pkg::psum_row_t bottom
);
    import systolic_pkg::*;

    logic  w_row_valid [ARRAY_DIM];

    data_t data_in     [ARRAY_DIM][ARRAY_DIM];
    logic  valid_in    [ARRAY_DIM][ARRAY_DIM];
    data_t data_out    [ARRAY_DIM][ARRAY_DIM];
    logic  valid_out   [ARRAY_DIM][ARRAY_DIM];
    psum_t psum_in     [ARRAY_DIM][ARRAY_DIM];
    psum_t psum_out    [ARRAY_DIM][ARRAY_DIM];
    logic  psum_valid  [ARRAY_DIM][ARRAY_DIM];

    for (genvar k = 0; k < ARRAY_DIM; k++) begin : g_row
        // weight row decode
        assign w_row_valid[k] = w_load.valid && (w_load.row == ROW_IDX_WIDTH'(k));

        for (genvar j = 0; j < ARRAY_DIM; j++) begin : g_col
            if (j == 0) begin : g_left
                assign data_in[k][j] = a_lanes.data[k];
                // lane k runs one cycle behind lane k-1, so does the valid
                // forwarded out of column 0 of the row above
                if (k == 0) begin : g_top
                    assign valid_in[k][j] = a_lanes.valid;
                end else begin : g_lower
                    assign valid_in[k][j] = valid_out[k-1][0];
                end
            end else begin : g_inner
                assign data_in[k][j]  = data_out[k][j-1];
                assign valid_in[k][j] = valid_out[k][j-1];
            end

            if (k == 0) begin : g_psum_top
                assign psum_in[k][j] = '0;
            end else begin : g_psum_chain
                assign psum_in[k][j] = psum_out[k-1][j];
            end

            systolic_pe u_pe (
                .s_clk         (s_clk),
                .s_rst         (s_rst),
                .weight_valid  (w_row_valid[k]),
                .weight        (w_load.weights[j]),
                .in_valid      (valid_in[k][j]),
                .in_data       (data_in[k][j]),
                .out_valid     (valid_out[k][j]),
                .out_data      (data_out[k][j]),
                .in_psum       (psum_in[k][j]),
                .out_psum_valid(psum_valid[k][j]),
                .out_psum      (psum_out[k][j])
            );
        end
    end

    // last column is the latest to finish, its valid marks the row
    always_comb begin
        bottom.valid = psum_valid[ARRAY_DIM-1][ARRAY_DIM-1];
        for (int j = 0; j < ARRAY_DIM; j++) begin
            bottom.psum[j] = psum_out[ARRAY_DIM-1][j];
        end
    end

endmodule

// File: design/systolic_mm_top.sv
// Top level of the systolic matrix-vector engine: c = a x W for signed 8-bit data.
// A result strobe follows each input strobe by 2*ARRAY_DIM+2 cycles.
`timescale 1ns/1ps

module systolic_mm_top (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  systolic_pkg::w_load_t   w_load,
    input  systolic_pkg::a_row_t    a_in,
    output systolic_pkg::psum_row_t c_out
);
    import systolic_pkg::*;

    a_row_t    a_lanes;
    psum_row_t bottom;

    // producer: input skew
    row_skew_feeder u_feeder (
        .s_clk  (s_clk),
        .s_rst  (s_rst),
        .a_in   (a_in),
        .a_lanes(a_lanes)
    );

    // PE mesh with stationary weights
    systolic_grid u_grid (
        .s_clk  (s_clk),
        .s_rst  (s_rst),
        .w_load (w_load),
        .a_lanes(a_lanes),
        .bottom (bottom)
    );

    // consumer: output deskew
    psum_deskew_collector u_collector (
        .s_clk (s_clk),
        .s_rst (s_rst),
        .bottom(bottom),
        .c_out (c_out)
    );

endmodule

// File: design/systolic_pe.sv
// One weight-stationary processing element of the grid.
// Data moves right after a cycle; the partial sum leaves two cycles after its data came in.
`timescale 1ns/1ps

module systolic_pe (
    input  logic                s_clk,
    input  logic                s_rst,
    input  logic                weight_valid,
    input  systolic_pkg::data_t weight,
    input  logic                in_valid,
    input  systolic_pkg::data_t in_data,
    output logic                out_valid,
    output systolic_pkg::data_t out_data,
    input  systolic_pkg::psum_t in_psum,
    output logic                out_psum_valid,
    output systolic_pkg::psum_t out_psum
);
    import systolic_pkg::*;

    logic  weight_valid_q;
    data_t weight_q;
    logic  prod_valid;
    psum_t product;

    // weight is taken on the first cycle of a strobe only
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            weight_valid_q <= 1'b0;
            weight_q       <= '0;
        end else begin
            weight_valid_q <= weight_valid;
            if (weight_valid && !weight_valid_q) begin
                weight_q <= weight;
            end
        end
    end

    // pass data to the PE on the right
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        out_data <= in_data;
    end

    booth_mult u_mult (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .in_valid    (in_valid),
        .multiplicand(in_data),
        .multiplier  (weight_q),
        .out_valid   (prod_valid),
        .product     (product)
    );

    // in_psum from above lines up with this PE's product
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            out_psum_valid <= 1'b0;
            out_psum       <= '0;
        end else begin
            out_psum_valid <= prod_valid;
            if (prod_valid) begin
                out_psum <= in_psum + product;
            end
        end
    end

endmodule

// File: design/systolic_pkg.sv
// Shared sizes, scalar types and row structs of the systolic matrix-vector engine.
// Every design module imports this package.
package systolic_pkg;

    // grid size, rows and columns are equal
    localparam int ARRAY_DIM = 4;

    // data and weight width
    localparam int DATA_WIDTH = 8;

    // wide enough for ARRAY_DIM products of two 8-bit signed values
    localparam int PSUM_WIDTH = 20;

    // bits needed to address one weight row
    localparam int ROW_IDX_WIDTH = $clog2(ARRAY_DIM);

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    // one input row, or the skewed lane bus into the grid
    typedef struct packed {
        logic                  valid;
        data_t [ARRAY_DIM-1:0] data;
    } a_row_t;

    // one weight row, written into grid row `row`
    typedef struct packed {
        logic                     valid;
        logic [ROW_IDX_WIDTH-1:0] row;
        data_t [ARRAY_DIM-1:0]    weights;
    } w_load_t;

    // one row of partial sums or results, element j is column j
    typedef struct packed {
        logic                  valid;
        psum_t [ARRAY_DIM-1:0] psum;
    } psum_row_t;

endpackage

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module systolic_mm_tb \
    -f vlog.f --Mdir obj_dir -o systolic_mm_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/systolic_mm_sim > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/systolic_mm_vectors.svh
// Directed stimulus table for the systolic engine testbench, included in its module body.
// Weight row loads and sent rows with their expected result rows, applied in order.

// lane and column 0 are element 0
//   send      0 loads weight row `row`, 1 sends an input row
//   lanes     weights of a load, or the input row of a send
//   expected  result row of a send, zero for a load
typedef struct packed {
    logic                     send;
    logic [ROW_IDX_WIDTH-1:0] row;
    data_t [ARRAY_DIM-1:0]    lanes;
    psum_t [ARRAY_DIM-1:0]    expected;
} vector_t;

vector_t vectors [$];

task automatic add_load(input int row, input int w0, input int w1, input int w2, input int w3);
    vector_t v;
    v       = '0;
    v.row   = ROW_IDX_WIDTH'(row);
    v.lanes = {data_t'(w3), data_t'(w2), data_t'(w1), data_t'(w0)};
    vectors.push_back(v);
endtask

task automatic add_send(input int a0, input int a1, input int a2, input int a3,
                        input int e0, input int e1, input int e2, input int e3);
    vector_t v;
    v          = '0;
    v.send     = 1'b1;
    v.lanes    = {data_t'(a3), data_t'(a2), data_t'(a1), data_t'(a0)};
    v.expected = {psum_t'(e3), psum_t'(e2), psum_t'(e1), psum_t'(e0)};
    vectors.push_back(v);
endtask

task automatic build_vector_table();
    // identity, the row comes back sign-extended
    add_load(0, 1, 0, 0, 0);
    add_load(1, 0, 1, 0, 0);
    add_load(2, 0, 0, 1, 0);
    add_load(3, 0, 0, 0, 1);
    add_send(5, -3, 127, -128,      5, -3, 127, -128);
    // general W, eight rows back to back
    add_load(0, 1, 2, 3, 4);
    add_load(1, -1, 0, 5, 2);
    add_load(2, 3, -2, 1, 0);
    add_load(3, 2, 1, -1, -3);
    add_send(1, 0, 0, 0,            1, 2, 3, 4);
    add_send(0, 1, 0, 0,            -1, 0, 5, 2);
    add_send(0, 0, 1, 0,            3, -2, 1, 0);
    add_send(0, 0, 0, 1,            2, 1, -1, -3);
    add_send(1, 1, 1, 1,            5, 1, 8, 3);
    add_send(2, -1, 3, -2,          8, -4, 6, 12);
    add_send(10, 20, -30, 40,       -20, 120, 60, -40);
    add_send(-7, 5, 0, 9,           6, -5, -5, -45);
    // reload with a scaled reversal
    add_load(0, 0, 0, 0, 2);
    add_load(1, 0, 0, -1, 0);
    add_load(2, 0, 3, 0, 0);
    add_load(3, 4, 0, 0, 0);
    add_send(2, -1, 3, -2,          -8, 9, 1, 4);
    add_send(1, 0, 0, 0,            0, 0, 0, 2);
    add_send(-128, 127, -128, 127,  508, -384, -127, -256);
    // Booth corner cases, all weights at -128
    add_load(0, -128, -128, -128, -128);
    add_load(1, -128, -128, -128, -128);
    add_load(2, -128, -128, -128, -128);
    add_load(3, -128, -128, -128, -128);
    add_send(-128, -128, -128, -128, 65536, 65536, 65536, 65536);
    add_send(127, 127, 127, 127,    -65024, -65024, -65024, -65024);
    add_send(127, -128, 127, -128,  256, 256, 256, 256);
    // all weights at 127
    add_load(0, 127, 127, 127, 127);
    add_load(1, 127, 127, 127, 127);
    add_load(2, 127, 127, 127, 127);
    add_load(3, 127, 127, 127, 127);
    add_send(127, 127, 127, 127,    64516, 64516, 64516, 64516);
    add_send(-128, -128, -128, -128, -65024, -65024, -65024, -65024);
    // mixed signs
    add_load(0, -128, 127, -1, 1);
    add_load(1, 127, -128, 1, -1);
    add_load(2, -128, -128, 127, 127);
    add_load(3, 1, -1, -128, 127);
    add_send(-128, 127, -128, 1,    48898, -16129, -16129, -16384);
endtask

// File: tb/systolic_mm_tb.sv
// Testbench for the systolic matrix-vector engine with a directed table and random rows.
// Each result row is checked against a dot product over the weights loaded here.
`timescale 1ns/1ps

module systolic_mm_tb;
    import systolic_pkg::*;

    // strobe to result latency in clock cycles
    localparam int LATENCY      = 2 * ARRAY_DIM + 2;
    localparam int DRAIN_CYCLES = 4 * LATENCY;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 40;

    typedef data_t [ARRAY_DIM-1:0] lane_vec_t;
    typedef psum_t [ARRAY_DIM-1:0] psum_vec_t;

    // one outstanding row of the scoreboard
    typedef struct packed {
        logic [31:0] sent_cycle;
        psum_vec_t   psum;
    } expect_t;

    logic      s_clk = 1'b0;
    logic      s_rst;
    w_load_t   w_load;
    a_row_t    a_in;
    psum_row_t c_out;

    data_t   shadow_w [ARRAY_DIM][ARRAY_DIM];
    expect_t expect_q [$];
    int      cycle = 0;
    int      recv_count = 0;

    `include "systolic_mm_vectors.svh"

    systolic_mm_top UUT (
        .s_clk (s_clk),
        .s_rst (s_rst),
        .w_load(w_load),
        .a_in  (a_in),
        .c_out (c_out)
    );

    always #5 s_clk = ~s_clk;

    always @(posedge s_clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h",
                                name, actual, expected));
        end
    endtask

    // step to just after the next rising edge
    // strobes drop unless driven again
    task automatic wait_cycle();
        @(posedge s_clk);
        #1;
        w_load.valid = 1'b0;
        a_in.valid   = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            wait_cycle();
        end
    endtask

    // c[j] = sum over k of a[k] * W[k][j]
    function automatic psum_vec_t dot_row(input lane_vec_t lanes);
        psum_vec_t res;
        int        acc;
        for (int j = 0; j < ARRAY_DIM; j++) begin
            acc = 0;
            for (int k = 0; k < ARRAY_DIM; k++) begin
                acc += int'($signed(lanes[k])) * int'($signed(shadow_w[k][j]));
            end
            res[j] = psum_t'(acc);
        end
        return res;
    endfunction

    function automatic lane_vec_t random_lanes();
        lane_vec_t v;
        for (int k = 0; k < ARRAY_DIM; k++) begin
            v[k] = data_t'($urandom);
        end
        return v;
    endfunction

    task automatic send_row(input lane_vec_t lanes);
        expect_t e;
        e.sent_cycle = cycle;
        e.psum       = dot_row(lanes);
        expect_q.push_back(e);
        a_in.valid = 1'b1;
        a_in.data  = lanes;
        wait_cycle();
    endtask

    task automatic load_weight_row(input int row, input lane_vec_t weights);
        w_load.valid   = 1'b1;
        w_load.row     = ROW_IDX_WIDTH'(row);
        w_load.weights = weights;
        for (int j = 0; j < ARRAY_DIM; j++) begin
            shadow_w[row][j] = weights[j];
        end
        wait_cycle();
        // each PE takes its weight on a rising strobe
        wait_cycle();
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (expect_q.size() != 0) begin
            if (waited == DRAIN_CYCLES) begin
                abort_run("timed out waiting for outstanding result rows");
            end
            wait_cycle();
            waited++;
        end
    endtask

    // scoreboard samples c_out at the falling edge where it is stable
    always @(negedge s_clk) begin : monitor
        expect_t exp_row;
        if (c_out.valid === 1'b1) begin
            if (expect_q.size() == 0) begin
                abort_run("result strobe on c_out with no row outstanding");
            end else begin
                exp_row = expect_q.pop_front();
                check_val("c_out latency", cycle - exp_row.sent_cycle, LATENCY);
                for (int j = 0; j < ARRAY_DIM; j++) begin
                    check_val($sformatf("c_out.psum[%0d]", j), 32'(c_out.psum[j]),
                              32'(exp_row.psum[j]));
                end
                recv_count++;
            end
        end else begin
            check_val("c_out.valid", 32'(c_out.valid), 32'd0);
        end
    end

    initial begin : stimulus
        psum_vec_t computed;
        int        expected_rows;
        void'($urandom(32'h61c72bdc));
        s_rst  = 1'b1;
        w_load = '0;
        a_in   = '0;
        for (int k = 0; k < ARRAY_DIM; k++) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                shadow_w[k][j] = '0;
            end
        end
        build_vector_table();
        expected_rows = NUM_RANDOM;
        foreach (vectors[i]) begin
            if (vectors[i].send) begin
                expected_rows++;
            end
        end
        repeat (RESET_CYCLES) @(posedge s_clk);
        #1;
        s_rst = 1'b0;
        // no result may show up before the first row
        idle_cycles(20);

        foreach (vectors[i]) begin
            if (vectors[i].send) begin
                computed = dot_row(vectors[i].lanes);
                for (int j = 0; j < ARRAY_DIM; j++) begin
                    check_val($sformatf("table[%0d].expected[%0d]", i, j),
                              32'(vectors[i].expected[j]), 32'(computed[j]));
                end
                send_row(vectors[i].lanes);
            end else begin
                drain_results();
                load_weight_row(int'(vectors[i].row), vectors[i].lanes);
            end
        end
        drain_results();

        // random W then rows with and without gaps
        for (int k = 0; k < ARRAY_DIM; k++) begin
            load_weight_row(k, random_lanes());
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if ($urandom_range(0, 1) == 1) begin
                idle_cycles($urandom_range(1, 3));
            end
            send_row(random_lanes());
        end
        drain_results();
        // a surplus strobe after the last row would show up here
        idle_cycles(LATENCY);

        if (recv_count == expected_rows) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run($sformatf("ERR result count: got 0x%08h, expected 0x%08h",
                                recv_count, expected_rows));
        end
    end

endmodule

// File: vlog.f
+incdir+tb
design/systolic_pkg.sv
design/booth_mult.sv
design/systolic_pe.sv
design/systolic_grid.sv
design/row_skew_feeder.sv
design/psum_deskew_collector.sv
design/systolic_mm_top.sv
tb/systolic_mm_tb.sv
